// ==== design/issue_defines.svh ====
`ifndef ISSUE_DEFINES_SVH
`define ISSUE_DEFINES_SVH

// instruction word and pc width
`define ISSUE_XLEN 32

// architectural register index width
`define ISSUE_REG_BITS 5

// pair entries held in each queue bank
`define ISSUE_QUEUE_PAIRS 8

`endif

// ==== design/issue_pkg.sv ====
`include "issue_defines.svh"

package issue_pkg;

  typedef logic [`ISSUE_XLEN-1:0] instr_word_t;
  typedef logic [`ISSUE_XLEN-1:0] pc_t;
  typedef logic [`ISSUE_REG_BITS-1:0] reg_idx_t;

  // one entry per pair, read position counts single instructions
  typedef logic [$clog2(`ISSUE_QUEUE_PAIRS)-1:0] pair_ptr_t;
  typedef logic [$clog2(`ISSUE_QUEUE_PAIRS):0] read_id_t;
  typedef logic [$clog2(`ISSUE_QUEUE_PAIRS)+1:0] occupancy_t;

  typedef struct packed {
    logic        valid;
    pc_t         pc;
    instr_word_t word0;
    instr_word_t word1;
  } fetch_pair_t;

  typedef struct packed {
    logic        valid;
    pc_t         pc;
    instr_word_t word;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    logic        wren;
    logic        rden1;
    logic        rden2;
    logic        is_mul;
    logic        is_lsu;
    logic        is_serial;
  } decoded_instr_t;

  typedef struct packed {
    decoded_instr_t slot0;
    decoded_instr_t slot1;
  } issue_pair_t;

  typedef struct packed {
    logic           wen;
    pair_ptr_t      waddr;
    decoded_instr_t wdata0;
    decoded_instr_t wdata1;
  } queue_write_t;

  typedef struct packed {
    pair_ptr_t raddr0;
    pair_ptr_t raddr1;
  } queue_read_t;

  typedef struct packed {
    decoded_instr_t rdata0;
    decoded_instr_t rdata1;
  } queue_data_t;

endpackage

// ==== design/pair_decoder.sv ====
`timescale 1ns/10ps

module pair_decoder (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    clear,
  input  issue_pkg::fetch_pair_t  fetch,
  output issue_pkg::issue_pair_t  decoded_pair
);

  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_fence  = 7'b0001111;
  localparam logic [6:0] op_system = 7'b1110011;
  localparam logic [6:0] funct7_mul = 7'b0000001;

  issue_pkg::issue_pair_t next_pair;

  function automatic issue_pkg::decoded_instr_t decode_word(
    input logic                   valid,
    input issue_pkg::pc_t         pc,
    input issue_pkg::instr_word_t word
  );
    issue_pkg::decoded_instr_t d;
    d = '0;
    d.valid = valid;
    d.pc = pc;
    d.word = word;
    d.rd = word[11:7];
    d.rs1 = word[19:15];
    d.rs2 = word[24:20];
    case (word[6:0])
      op_reg: begin
        d.wren = 1'b1;
        d.rden1 = 1'b1;
        d.rden2 = 1'b1;
        d.is_mul = (word[31:25] == funct7_mul);
      end
      op_imm: begin
        d.wren = 1'b1;
        d.rden1 = 1'b1;
      end
      op_load: begin
        d.wren = 1'b1;
        d.rden1 = 1'b1;
        d.is_lsu = 1'b1;
      end
      op_store: begin
        d.rden1 = 1'b1;
        d.rden2 = 1'b1;
        d.is_lsu = 1'b1;
      end
      op_branch: begin
        d.rden1 = 1'b1;
        d.rden2 = 1'b1;
      end
      op_fence, op_system: begin
        d.rden1 = 1'b1;
        d.is_serial = 1'b1;
      end
      default: ;
    endcase
    // x0 is never a real destination
    if (d.rd == '0) begin
      d.wren = 1'b0;
    end
    return d;
  endfunction

  always_comb begin
    next_pair.slot0 = decode_word(fetch.valid, fetch.pc, fetch.word0);
    next_pair.slot1 = decode_word(fetch.valid, fetch.pc + issue_pkg::pc_t'(4), fetch.word1);
  end

  always_ff @(posedge clock) begin
    decoded_pair <= next_pair;
    if (!reset || clear) begin
      decoded_pair.slot0.valid <= 1'b0;
      decoded_pair.slot1.valid <= 1'b0;
    end
  end

  // ##########################################################################
  // pairs always arrive whole
  pair_whole: assert property (@(posedge clock) disable iff (!reset)
    decoded_pair.slot1.valid == decoded_pair.slot0.valid);

endmodule

// ==== design/pair_queue.sv ====
`timescale 1ns/10ps
`include "issue_defines.svh"

module pair_queue (
  input  logic                    clock,
  input  issue_pkg::queue_write_t queue_write,
  input  issue_pkg::queue_read_t  queue_read,
  output issue_pkg::queue_data_t  queue_data
);

  // bank0 keeps the older slot of each pair, bank1 the younger one
  issue_pkg::decoded_instr_t bank0 [`ISSUE_QUEUE_PAIRS];
  issue_pkg::decoded_instr_t bank1 [`ISSUE_QUEUE_PAIRS];

  always_ff @(posedge clock) begin
    if (queue_write.wen) begin
      bank0[queue_write.waddr] <= queue_write.wdata0;
      bank1[queue_write.waddr] <= queue_write.wdata1;
    end
  end

  // asynchronous read, each bank at its own address
  always_comb begin
    queue_data.rdata0 = bank0[queue_read.raddr0];
    queue_data.rdata1 = bank1[queue_read.raddr1];
  end

  waddr_known: assert property (@(posedge clock)
    queue_write.wen |-> !$isunknown(queue_write.waddr));

endmodule

// ==== design/issue_ctrl.sv ====
`timescale 1ns/10ps
`include "issue_defines.svh"

module issue_ctrl (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    clear,
  input  logic                    exec_stall,
  input  issue_pkg::issue_pair_t  decoded_pair,
  output issue_pkg::queue_write_t queue_write,
  output issue_pkg::queue_read_t  queue_read,
  input  issue_pkg::queue_data_t  queue_data,
  output issue_pkg::issue_pair_t  issue,
  output logic                    fetch_stall
);

  localparam int capacity = 2 * `ISSUE_QUEUE_PAIRS;
  localparam int stall_level = capacity - 2;

  issue_pkg::pair_ptr_t      wptr;
  issue_pkg::read_id_t       rid;
  issue_pkg::occupancy_t     occupancy;

  logic                      wen;
  issue_pkg::pair_ptr_t      entry;
  issue_pkg::pair_ptr_t      next_entry;
  logic                      odd;
  issue_pkg::decoded_instr_t older;
  issue_pkg::decoded_instr_t younger;
  issue_pkg::occupancy_t     avail;
  logic                      single;
  logic                      raw;
  logic [1:0]                take;
  issue_pkg::occupancy_t     occ_next;
  issue_pkg::occupancy_t     projected;

  // ##########################################################################
  // write side

  assign wen = decoded_pair.slot0.valid & ~clear;

  always_comb begin
    queue_write.wen = wen;
    queue_write.waddr = wptr;
    queue_write.wdata0 = decoded_pair.slot0;
    queue_write.wdata1 = decoded_pair.slot1;
  end

  // ##########################################################################
  // read side, oldest two instructions

  assign entry = rid[$bits(rid)-1:1];
  assign odd = rid[0];
  assign next_entry = entry + 1'b1;

  always_comb begin
    queue_read.raddr0 = odd ? next_entry : entry;
    queue_read.raddr1 = entry;
    if (!odd) begin
      // empty queue, the incoming pair is read straight through
      if (wen && wptr == entry) begin
        older = decoded_pair.slot0;
        younger = decoded_pair.slot1;
      end else begin
        older = queue_data.rdata0;
        younger = queue_data.rdata1;
      end
    end else begin
      older = queue_data.rdata1;
      if (wen && wptr == next_entry) begin
        younger = decoded_pair.slot0;
      end else begin
        younger = queue_data.rdata0;
      end
    end
  end

  // ##########################################################################
  // pairing and issue count

  assign avail = occupancy + (wen ? issue_pkg::occupancy_t'(2) : issue_pkg::occupancy_t'(0));

  always_comb begin
    single = older.is_serial | younger.is_serial;
    single = single | (older.is_mul & younger.is_mul);
    single = single | (older.is_lsu & younger.is_lsu);
    raw = older.wren & ((younger.rden1 & (younger.rs1 == older.rd)) |
                        (younger.rden2 & (younger.rs2 == older.rd)));
  end

  always_comb begin
    if (exec_stall || clear || avail == '0) begin
      take = 2'd0;
    end else if (avail == issue_pkg::occupancy_t'(1) || single || raw) begin
      take = 2'd1;
    end else begin
      take = 2'd2;
    end
  end

  always_comb begin
    issue.slot0 = (take != 2'd0) ? older : '0;
    issue.slot1 = (take == 2'd2) ? younger : '0;
  end

  assign occ_next = avail - issue_pkg::occupancy_t'(take);

  // a pair may already be entering the decoder while fetch_stall is low
  assign projected = occ_next + (fetch_stall ? issue_pkg::occupancy_t'(0) :
                                               issue_pkg::occupancy_t'(2));

  always_ff @(posedge clock) begin
    if (!reset || clear) begin
      wptr <= '0;
      rid <= '0;
      occupancy <= '0;
      fetch_stall <= 1'b0;
    end else begin
      if (wen) begin
        wptr <= wptr + 1'b1;
      end
      rid <= rid + take;
      occupancy <= occ_next;
      fetch_stall <= (projected > stall_level);
    end
  end

  // ##########################################################################
  occupancy_bound: assert property (@(posedge clock) disable iff (!reset)
    occupancy <= capacity);

  issue_in_order: assert property (@(posedge clock) disable iff (!reset)
    issue.slot1.valid |-> issue.slot0.valid);

endmodule

// ==== design/issue_unit.sv ====
`timescale 1ns/10ps

module issue_unit (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   clear,
  input  logic                   exec_stall,
  input  issue_pkg::fetch_pair_t fetch,
  output issue_pkg::issue_pair_t issue,
  output logic                   fetch_stall
);

  issue_pkg::issue_pair_t  decoded_pair;
  issue_pkg::queue_write_t queue_write;
  issue_pkg::queue_read_t  queue_read;
  issue_pkg::queue_data_t  queue_data;

  pair_decoder i_pair_decoder (
    .clock        (clock),
    .reset        (reset),
    .clear        (clear),
    .fetch        (fetch),
    .decoded_pair (decoded_pair)
  );

  pair_queue i_pair_queue (
    .clock       (clock),
    .queue_write (queue_write),
    .queue_read  (queue_read),
    .queue_data  (queue_data)
  );

  issue_ctrl i_issue_ctrl (
    .clock        (clock),
    .reset        (reset),
    .clear        (clear),
    .exec_stall   (exec_stall),
    .decoded_pair (decoded_pair),
    .queue_write  (queue_write),
    .queue_read   (queue_read),
    .queue_data   (queue_data),
    .issue        (issue),
    .fetch_stall  (fetch_stall)
  );

endmodule

// ==== verification/issue_unit_tb.sv ====
`timescale 1ns/10ps

module issue_unit_tb;

  localparam logic [6:0] op_reg   = 7'b0110011;
  localparam logic [6:0] op_imm   = 7'b0010011;
  localparam logic [6:0] op_load  = 7'b0000011;
  localparam logic [6:0] op_store = 7'b0100011;
  localparam logic [6:0] op_fence = 7'b0001111;

  logic                      clock;
  logic                      reset;
  logic                      clear;
  logic                      exec_stall;
  issue_pkg::fetch_pair_t    fetch;
  issue_pkg::issue_pair_t    issue;
  logic                      fetch_stall;
  integer                    seed;
  issue_pkg::pc_t            pc_next;
  issue_pkg::decoded_instr_t model [$];
  issue_pkg::occupancy_t     expected;

  issue_unit i_issue_unit (
    .clock       (clock),
    .reset       (reset),
    .clear       (clear),
    .exec_stall  (exec_stall),
    .fetch       (fetch),
    .issue       (issue),
    .fetch_stall (fetch_stall)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // ##########################################################################
  // reference model

  function automatic issue_pkg::decoded_instr_t decode_ref(input issue_pkg::pc_t pc,
                                                           input issue_pkg::instr_word_t word);
    issue_pkg::decoded_instr_t r;
    logic [5:0] flags;
    // wren, rden1, rden2, is_mul, is_lsu, is_serial
    case (word[6:0])
      7'b0110011: flags = {3'b111, word[31:25] == 7'b0000001, 2'b00};
      7'b0010011: flags = 6'b110000;
      7'b0000011: flags = 6'b110010;
      7'b0100011: flags = 6'b011010;
      7'b1100011: flags = 6'b011000;
      7'b0001111, 7'b1110011: flags = 6'b010001;
      default: flags = 6'b000000;
    endcase
    r = '0;
    r.valid = 1'b1;
    r.pc = pc;
    r.word = word;
    r.rd = word[11:7];
    r.rs1 = word[19:15];
    r.rs2 = word[24:20];
    {r.wren, r.rden1, r.rden2, r.is_mul, r.is_lsu, r.is_serial} = flags;
    if (r.rd == '0) r.wren = 1'b0;
    return r;
  endfunction

  function automatic logic pair_ok(input issue_pkg::decoded_instr_t a,
                                   input issue_pkg::decoded_instr_t b);
    logic hazard;
    hazard = a.wren && ((b.rden1 && b.rs1 == a.rd) || (b.rden2 && b.rs2 == a.rd));
    return !(a.is_serial || b.is_serial || (a.is_mul && b.is_mul) ||
             (a.is_lsu && b.is_lsu) || hazard);
  endfunction

  function automatic issue_pkg::occupancy_t issued_count(input issue_pkg::issue_pair_t p);
    return issue_pkg::occupancy_t'(p.slot0.valid) + issue_pkg::occupancy_t'(p.slot1.valid);
  endfunction

  function automatic issue_pkg::instr_word_t make_word(input logic [6:0] op,
      input logic [6:0] funct7, input int rd, input int rs1, input int rs2);
    return {funct7, 5'(rs2), 5'(rs1), 3'b000, 5'(rd), op};
  endfunction

  // registers kept in x0..x3 so that dependences show up often
  function automatic issue_pkg::instr_word_t random_word();
    int pick;
    logic [6:0] op;
    pick = {$random(seed)} % 9;
    case (pick)
      0, 1: op = op_reg;
      2: op = op_imm;
      3: op = op_load;
      4: op = op_store;
      5: op = 7'b1100011;
      6: op = op_fence;
      7: op = 7'b1110011;
      default: op = 7'b0110111;
    endcase
    return make_word(op, (pick == 1) ? 7'b0000001 : 7'b0000000,
                     {$random(seed)} % 4, {$random(seed)} % 4, {$random(seed)} % 4);
  endfunction

  // ##########################################################################
  // checks and stimulus

  task automatic abort_run();
    $display("CHECKS FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_instr(input string name, input issue_pkg::decoded_instr_t exp,
                             input issue_pkg::decoded_instr_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_count(input string name, input issue_pkg::occupancy_t exp,
                             input issue_pkg::occupancy_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
      abort_run();
    end
  endtask

  task automatic next_cycle();
    @(posedge clock);
    #10;
  endtask

  task automatic send_pair(input issue_pkg::instr_word_t w0, input issue_pkg::instr_word_t w1);
    int waited;
    waited = 0;
    fetch.valid = 1'b0;
    while (fetch_stall) begin
      next_cycle();
      waited++;
      if (waited > 100) begin
        $display("timeout: fetch_stall stayed high while a pair was waiting");
        abort_run();
      end
    end
    fetch.valid = 1'b1;
    fetch.pc = pc_next;
    fetch.word0 = w0;
    fetch.word1 = w1;
    pc_next = pc_next + 32'd8;
    next_cycle();
    fetch.valid = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (model.size() != 0) begin
      next_cycle();
      waited++;
      if (waited > 200) begin
        $display("timeout: queued instructions did not drain");
        abort_run();
      end
    end
  endtask

  task automatic directed_pair(input string name, input issue_pkg::instr_word_t w0,
                               input issue_pkg::instr_word_t w1,
                               input issue_pkg::occupancy_t count);
    wait_drain();
    send_pair(w0, w1);
    @(negedge clock);
    check_count(name, count, issued_count(issue));
    next_cycle();
    wait_drain();
  endtask

  // queue model filled at the fetch edge and drained by what issues
  initial begin
    forever begin
      @(posedge clock);
      if (!reset || clear) begin
        model.delete();
      end else if (fetch.valid) begin
        model.push_back(decode_ref(fetch.pc, fetch.word0));
        model.push_back(decode_ref(fetch.pc + 32'd4, fetch.word1));
      end
      @(negedge clock);
      if (exec_stall || clear || model.size() == 0) begin
        expected = 0;
      end else if (model.size() == 1 || !pair_ok(model[0], model[1])) begin
        expected = 1;
      end else begin
        expected = 2;
      end
      check_count("issue count", expected, issued_count(issue));
      if (expected == 0) begin
        check_instr("empty slot0", '0, issue.slot0);
      end else begin
        check_instr("issued slot0", model.pop_front(), issue.slot0);
      end
      if (expected == 2) begin
        check_instr("issued slot1", model.pop_front(), issue.slot1);
      end else begin
        check_instr("unused slot1", '0, issue.slot1);
      end
    end
  end

  initial begin
    int waited;
    seed = 4494;
    reset = 1'b0;
    clear = 1'b0;
    exec_stall = 1'b0;
    fetch = '0;
    pc_next = 32'h0000_1000;
    repeat (3) @(posedge clock);
    #10;
    reset = 1'b1;
    next_cycle();
    check_instr("slot0 after reset", '0, issue.slot0);
    check_instr("slot1 after reset", '0, issue.slot1);
    check_flag("fetch_stall after reset", 1'b0, fetch_stall);

    directed_pair("raw pair", make_word(op_imm, 0, 1, 2, 0), make_word(op_reg, 0, 3, 1, 2), 1);
    directed_pair("mul pair", make_word(op_reg, 1, 1, 2, 3), make_word(op_reg, 1, 4, 5, 6), 1);
    directed_pair("load store", make_word(op_load, 0, 1, 2, 0),
                  make_word(op_store, 0, 0, 3, 4), 1);
    directed_pair("fence pair", make_word(op_fence, 0, 0, 0, 0), make_word(op_imm, 0, 5, 6, 0), 1);
    directed_pair("independent", make_word(op_reg, 0, 1, 2, 3), make_word(op_reg, 0, 4, 5, 6), 2);

    // back-pressure until the queue asks fetch to stop
    exec_stall = 1'b1;
    waited = 0;
    while (!fetch_stall) begin
      send_pair(random_word(), random_word());
      waited++;
      if (waited > 20) begin
        $display("timeout: fetch_stall did not rise under exec_stall");
        abort_run();
      end
    end
    repeat (3) next_cycle();
    exec_stall = 1'b0;
    wait_drain();

    // flush pairs that are still queued
    exec_stall = 1'b1;
    repeat (3) send_pair(random_word(), random_word());
    clear = 1'b1;
    next_cycle();
    clear = 1'b0;
    exec_stall = 1'b0;
    repeat (2) next_cycle();
    repeat (4) send_pair(random_word(), random_word());
    wait_drain();

    repeat (120) begin
      exec_stall = ({$random(seed)} % 4) == 0;
      if (fetch_stall) next_cycle();
      else send_pair(random_word(), random_word());
    end
    exec_stall = 1'b0;
    wait_drain();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// ==== issue_unit.f ====
+incdir+design
design/issue_pkg.sv
design/pair_decoder.sv
design/pair_queue.sv
design/issue_ctrl.sv
design/issue_unit.sv
verification/issue_unit_tb.sv
